//--- csr_index_defines.svh
/* Global widths and constants of the CSR index engine.
   Included by the package and by the testbench. */

`ifndef CSR_INDEX_DEFINES_SVH
`define CSR_INDEX_DEFINES_SVH

// Width of one response data word
`define CSR_DATA_W 32

// Width of an index into the CSR array
`define CSR_INDEX_W 16

// Width of a memory request address
`define CSR_ADDR_W 32

// One bit wider than an index so a full range never wraps
`define CSR_COUNT_W 17

// Bytes per addressed element
`define CSR_WORD_BYTES 4

`endif

//--- csr_index_pkg.sv
/* Shared types of the CSR index engine: word types, response routing
   tags, configuration field names and generator states. */

`include "csr_index_defines.svh"

package csr_index_pkg;

    typedef logic [`CSR_DATA_W-1:0]  data_t;
    typedef logic [`CSR_INDEX_W-1:0] index_t;
    typedef logic [`CSR_ADDR_W-1:0]  addr_t;

    // Destination of a response word
    typedef enum logic {
        DEST_CONFIG    = 1'b0,
        DEST_GENERATOR = 1'b1
    } csr_dest_e;

    // Field written by a configuration response
    typedef enum logic [1:0] {
        FIELD_INDEX_START = 2'd0,
        FIELD_INDEX_END   = 2'd1,
        FIELD_STRIDE      = 2'd2,
        FIELD_BASE_ADDR   = 2'd3
    } cfg_field_e;

    typedef enum logic [1:0] {
        GEN_IDLE  = 2'd0,
        GEN_ISSUE = 2'd1,
        GEN_DRAIN = 2'd2
    } gen_state_e;

endpackage : csr_index_pkg

//--- csr_index_input_stage.sv
/* Input register stage. Captures the start strobe and the response stream
   and splits responses into configuration writes and generator returns. */

`timescale 1ns/1ps

module csr_index_input_stage (
    input  logic                       ap_clk,
    input  logic                       areset_csr_engine,
    input  logic                       start_i,
    input  logic                       rsp_valid_i,
    input  csr_index_pkg::csr_dest_e   rsp_dest_i,
    input  csr_index_pkg::cfg_field_e  rsp_field_i,
    input  csr_index_pkg::data_t       rsp_data_i,
    output logic                       start_o,
    output logic                       cfg_wr_o,
    output csr_index_pkg::cfg_field_e  cfg_field_o,
    output csr_index_pkg::data_t       cfg_data_o,
    output logic                       gen_rsp_o
);
    import csr_index_pkg::*;

    // ------------------------------------------------------------
    // Strobes, decoded by destination
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            start_o   <= 1'b0;
            cfg_wr_o  <= 1'b0;
            gen_rsp_o <= 1'b0;
        end else begin
            start_o   <= start_i;
            cfg_wr_o  <= rsp_valid_i && (rsp_dest_i == DEST_CONFIG);
            gen_rsp_o <= rsp_valid_i && (rsp_dest_i == DEST_GENERATOR);
        end
    end

    // ------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------
    // Only meaningful alongside cfg_wr_o
    always_ff @(posedge ap_clk) begin
        cfg_field_o <= rsp_field_i;
        cfg_data_o  <= rsp_data_i;
    end

endmodule : csr_index_input_stage

//--- csr_index_config.sv
/* Configuration block. Stores the index range, stride and base address
   written by configuration responses and flags when all four are set. */

`timescale 1ns/1ps

module csr_index_config (
    input  logic                       ap_clk,
    input  logic                       areset_csr_engine,
    input  logic                       cfg_wr_i,
    input  csr_index_pkg::cfg_field_e  cfg_field_i,
    input  csr_index_pkg::data_t       cfg_data_i,
    output logic                       cfg_ready_o,
    output csr_index_pkg::index_t      index_start_o,
    output csr_index_pkg::index_t      index_end_o,
    output csr_index_pkg::index_t      stride_o,
    output csr_index_pkg::addr_t       base_addr_o
);
    import csr_index_pkg::*;

    // One bit per field, indexed by the field encoding
    logic [3:0] written_q;

    // ------------------------------------------------------------
    // Field write tracking
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            written_q <= 4'b0000;
        end else if (cfg_wr_i) begin
            written_q[cfg_field_i] <= 1'b1;
        end
    end

    assign cfg_ready_o = &written_q;

    // ------------------------------------------------------------
    // Field storage
    // ------------------------------------------------------------
    // Index fields keep only the low bits of the word
    always_ff @(posedge ap_clk) begin
        if (cfg_wr_i) begin
            case (cfg_field_i)
                FIELD_INDEX_START: begin
                    index_start_o <= index_t'(cfg_data_i);
                end
                FIELD_INDEX_END: begin
                    index_end_o <= index_t'(cfg_data_i);
                end
                FIELD_STRIDE: begin
                    stride_o <= index_t'(cfg_data_i);
                end
                FIELD_BASE_ADDR: begin
                    base_addr_o <= addr_t'(cfg_data_i);
                end
            endcase
        end
    end

endmodule : csr_index_config

//--- csr_index_generator.sv
/* Request generator. On an accepted start it walks the index range, issues
   one read per index and raises done once every read has returned. */

`timescale 1ns/1ps

`include "csr_index_defines.svh"

module csr_index_generator (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  logic                   start_i,
    input  logic                   cfg_ready_i,
    input  csr_index_pkg::index_t  index_start_i,
    input  csr_index_pkg::index_t  index_end_i,
    input  csr_index_pkg::index_t  stride_i,
    input  csr_index_pkg::addr_t   base_addr_i,
    input  logic                   rsp_i,
    output logic                   req_valid_o,
    output csr_index_pkg::addr_t   req_addr_o,
    output logic                   done_o
);
    import csr_index_pkg::*;

    gen_state_e state;

    // Job copy of the configuration
    index_t end_q;
    index_t stride_q;
    addr_t  base_q;

    // One extra bit so index plus stride cannot wrap below the end
    logic [`CSR_INDEX_W:0]   cur_index;
    logic [`CSR_COUNT_W-1:0] outstanding;

    logic                  accept;
    logic                  issue;
    logic                  last_issue;
    logic                  rsp_take;
    logic [`CSR_INDEX_W:0] issue_index;
    logic [`CSR_INDEX_W:0] next_index;
    index_t                end_sel;
    index_t                stride_sel;
    addr_t                 base_sel;

    // ------------------------------------------------------------
    // Issue decision
    // ------------------------------------------------------------
    // On accept the first request uses the live configuration directly
    always_comb begin
        accept = (state == GEN_IDLE) && start_i && cfg_ready_i;
        if (accept) begin
            issue_index = {1'b0, index_start_i};
            end_sel     = index_end_i;
            // A zero stride would never leave the range
            stride_sel  = (stride_i == '0) ? index_t'(1) : stride_i;
            base_sel    = base_addr_i;
        end else begin
            issue_index = cur_index;
            end_sel     = end_q;
            stride_sel  = stride_q;
            base_sel    = base_q;
        end
        issue      = (state == GEN_ISSUE) || (accept && (index_start_i < index_end_i));
        next_index = issue_index + {1'b0, stride_sel};
        last_issue = next_index >= {1'b0, end_sel};
        // Stray returns with nothing in flight are dropped
        rsp_take   = rsp_i && (outstanding != '0);
    end

    // ------------------------------------------------------------
    // State machine and done
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state  <= GEN_IDLE;
            done_o <= 1'b0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (accept && issue) begin
                        done_o <= 1'b0;
                        state  <= last_issue ? GEN_DRAIN : GEN_ISSUE;
                    end else if (accept) begin
                        // Empty range completes at once
                        done_o <= 1'b1;
                    end
                end
                GEN_ISSUE: begin
                    if (last_issue) begin
                        state <= GEN_DRAIN;
                    end
                end
                GEN_DRAIN: begin
                    if (outstanding == '0) begin
                        done_o <= 1'b1;
                        state  <= GEN_IDLE;
                    end
                end
                default: begin
                    state <= GEN_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Outstanding reads and request outputs
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            outstanding <= '0;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= issue;
            if (issue && !rsp_take) begin
                outstanding <= outstanding + 1'b1;
            end else if (!issue && rsp_take) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            end_q    <= index_end_i;
            stride_q <= stride_sel;
            base_q   <= base_addr_i;
        end
        if (issue) begin
            cur_index <= next_index;
        end
        req_addr_o <= base_sel
                    + addr_t'(issue_index[`CSR_INDEX_W-1:0]) * addr_t'(`CSR_WORD_BYTES);
    end

endmodule : csr_index_generator

//--- csr_index_engine.sv
/* Top level of the CSR index engine. Wires the input stage, the
   configuration block and the request generator together. */

`timescale 1ns/1ps

module csr_index_engine (
    input  logic                       ap_clk,
    input  logic                       areset_csr_engine,
    input  logic                       start_i,
    input  logic                       rsp_valid_i,
    input  csr_index_pkg::csr_dest_e   rsp_dest_i,
    input  csr_index_pkg::cfg_field_e  rsp_field_i,
    input  csr_index_pkg::data_t       rsp_data_i,
    output logic                       req_valid_o,
    output csr_index_pkg::addr_t       req_addr_o,
    output logic                       done_o
);
    import csr_index_pkg::*;

    // Input stage outputs
    logic       start_q;
    logic       cfg_wr;
    cfg_field_e cfg_field;
    data_t      cfg_data;
    logic       gen_rsp;

    // Configuration block outputs
    logic   cfg_ready;
    index_t index_start;
    index_t index_end;
    index_t stride;
    addr_t  base_addr;

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------
    csr_index_input_stage csr_index_input_stage_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .start_i           (start_i),
        .rsp_valid_i       (rsp_valid_i),
        .rsp_dest_i        (rsp_dest_i),
        .rsp_field_i       (rsp_field_i),
        .rsp_data_i        (rsp_data_i),
        .start_o           (start_q),
        .cfg_wr_o          (cfg_wr),
        .cfg_field_o       (cfg_field),
        .cfg_data_o        (cfg_data),
        .gen_rsp_o         (gen_rsp)
    );

    csr_index_config csr_index_config_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .cfg_wr_i          (cfg_wr),
        .cfg_field_i       (cfg_field),
        .cfg_data_i        (cfg_data),
        .cfg_ready_o       (cfg_ready),
        .index_start_o     (index_start),
        .index_end_o       (index_end),
        .stride_o          (stride),
        .base_addr_o       (base_addr)
    );

    csr_index_generator csr_index_generator_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .start_i           (start_q),
        .cfg_ready_i       (cfg_ready),
        .index_start_i     (index_start),
        .index_end_i       (index_end),
        .stride_i          (stride),
        .base_addr_i       (base_addr),
        .rsp_i             (gen_rsp),
        .req_valid_o       (req_valid_o),
        .req_addr_o        (req_addr_o),
        .done_o            (done_o)
    );

endmodule : csr_index_engine

//--- csr_index_engine_asserts.sv
/* Concurrent checks on the engine outputs and generator state.
   Bound to the engine top level from the testbench. */

`timescale 1ns/1ps

module csr_index_engine_asserts (
    input logic                       ap_clk,
    input logic                       areset_csr_engine,
    input logic                       req_valid_i,
    input logic                       done_i,
    input logic                       cfg_ready_i,
    input csr_index_pkg::gen_state_e  gen_state_i
);
    import csr_index_pkg::*;

    // Count of failed assertions
    int assert_errors = 0;

    // ------------------------------------------------------------
    // Output properties
    // ------------------------------------------------------------
    req_done_excl: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(req_valid_i && done_i))
        else begin
            assert_errors++;
            $error("req_valid_o and done_o high in the same cycle");
        end

    // Requests only leave while a job is running
    req_not_idle: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        req_valid_i |-> (gen_state_i != GEN_IDLE))
        else begin
            assert_errors++;
            $error("req_valid_o high while the generator is idle");
        end

    req_after_ready: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        req_valid_i |-> cfg_ready_i)
        else begin
            assert_errors++;
            $error("req_valid_o high before the configuration is complete");
        end

endmodule : csr_index_engine_asserts

//--- tb_csr_index_engine.sv
/* Testbench for the CSR index engine. Configures jobs, answers each read
   after a random delay and checks the request stream against a model. */

`timescale 1ns/1ps

`include "csr_index_defines.svh"

module tb_csr_index_engine;
    import csr_index_pkg::*;

    localparam int TIMEOUT = 400;
    localparam int WINDOW  = 40;

    logic       ap_clk;
    logic       areset_csr_engine;
    logic       start_i;
    logic       rsp_valid_i;
    csr_dest_e  rsp_dest_i;
    cfg_field_e rsp_field_i;
    data_t      rsp_data_i;
    logic       req_valid_o;
    addr_t      req_addr_o;
    logic       done_o;

    integer     seed = 65335;
    int         cycle = 0;
    int         errors = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         start_cycle = 0;
    int         first_req_cycle = -1;
    int         rsp_sent = 0;
    bit         hold_rsp = 1'b0;
    addr_t      exp_q[$];
    addr_t      got_q[$];
    int         due_q[$];
    data_t      cfg_q[$];
    cfg_field_e cfg_field_q[$];

    csr_index_engine csr_index_engine_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .start_i           (start_i),
        .rsp_valid_i       (rsp_valid_i),
        .rsp_dest_i        (rsp_dest_i),
        .rsp_field_i       (rsp_field_i),
        .rsp_data_i        (rsp_data_i),
        .req_valid_o       (req_valid_o),
        .req_addr_o        (req_addr_o),
        .done_o            (done_o)
    );

    bind csr_index_engine csr_index_engine_asserts asserts_inst (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .req_valid_i       (req_valid_o),
        .done_i            (done_o),
        .cfg_ready_i       (cfg_ready),
        .gen_state_i       (csr_index_generator_inst.state)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------
    // Request monitor and response driver
    // ------------------------------------------------------------
    always @(negedge ap_clk) begin
        int due;
        if (req_valid_o) begin
            if (got_q.size() == 0) begin
                first_req_cycle = cycle;
            end
            got_q.push_back(req_addr_o);
            // Return 0 to 5 cycles later and at most one response per cycle
            due = cycle + 1 + ($unsigned($random(seed)) % 6);
            if (due_q.size() > 0 && due <= due_q[$]) begin
                due = due_q[$] + 1;
            end
            due_q.push_back(due);
        end
    end

    always @(posedge ap_clk) begin
        #1;
        rsp_valid_i = 1'b0;
        if (!hold_rsp && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            rsp_valid_i = 1'b1;
            rsp_dest_i  = DEST_GENERATOR;
            rsp_data_i  = $random(seed);
            rsp_sent++;
        end else if (cfg_q.size() > 0) begin
            rsp_valid_i = 1'b1;
            rsp_dest_i  = DEST_CONFIG;
            rsp_field_i = cfg_field_q.pop_front();
            rsp_data_i  = cfg_q.pop_front();
        end
    end

    // ------------------------------------------------------------
    // Checks, model and job sequencing
    // ------------------------------------------------------------
    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Index fields use the low bits only
    // A zero stride steps by one
    function automatic void build_model(input data_t s, input data_t e, input data_t st,
                                        input data_t b);
        longint idx;
        longint step;
        exp_q.delete();
        step = (st[`CSR_INDEX_W-1:0] == 0) ? 1 : st[`CSR_INDEX_W-1:0];
        idx  = s[`CSR_INDEX_W-1:0];
        while (idx < e[`CSR_INDEX_W-1:0]) begin
            exp_q.push_back(b + idx * `CSR_WORD_BYTES);
            idx += step;
        end
    endfunction

    task automatic write_field(input cfg_field_e field, input data_t data);
        cfg_field_q.push_back(field);
        cfg_q.push_back(data);
    endtask

    task automatic send_config();
        int t;
        t = 0;
        while (cfg_q.size() > 0 && t < TIMEOUT) begin
            @(posedge ap_clk);
            t++;
        end
        if (cfg_q.size() > 0) begin
            errors++;
            $display("Timeout: configuration words were not all sent");
        end
        repeat (2) @(posedge ap_clk);
    endtask

    task automatic configure(input data_t s, input data_t e, input data_t st, input data_t b);
        write_field(FIELD_INDEX_START, s);
        write_field(FIELD_INDEX_END, e);
        write_field(FIELD_STRIDE, st);
        write_field(FIELD_BASE_ADDR, b);
        send_config();
        build_model(s, e, st, b);
    endtask

    task automatic run_job(input string name, input bit ready, input bit withhold);
        int t;
        int bad;
        int err_before;
        err_before      = errors;
        bad             = 0;
        got_q.delete();
        rsp_sent        = 0;
        first_req_cycle = -1;
        hold_rsp        = withhold;
        @(posedge ap_clk);
        #1;
        start_i     = 1'b1;
        start_cycle = cycle;
        @(posedge ap_clk);
        #1;
        start_i = 1'b0;
        if (!ready) begin
            for (t = 0; t < WINDOW; t++) begin
                @(negedge ap_clk);
                if (req_valid_o || done_o) begin
                    bad++;
                end
            end
            check_value("cycles with activity before config ready", bad, 0);
        end else begin
            if (withhold) begin
                t = 0;
                while (got_q.size() < exp_q.size() && t < TIMEOUT) begin
                    @(negedge ap_clk);
                    t++;
                end
                if (got_q.size() < exp_q.size()) begin
                    errors++;
                    $display("Timeout: not all requests were issued while responses were held");
                end
                for (t = 0; t < WINDOW; t++) begin
                    @(negedge ap_clk);
                    if (done_o) begin
                        bad++;
                    end
                end
                check_value("cycles with done while responses withheld", bad, 0);
                hold_rsp = 1'b0;
            end
            t = 0;
            while ((cycle < start_cycle + 2 || !done_o) && t < TIMEOUT) begin
                @(negedge ap_clk);
                t++;
            end
            if (!done_o) begin
                errors++;
                $display("Timeout: done_o did not rise within %0d cycles", TIMEOUT);
            end
            check_value("request count", got_q.size(), exp_q.size());
            for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
                check_value("request address", got_q[i], exp_q[i]);
            end
            check_value("responses returned before done", rsp_sent, exp_q.size());
            if (exp_q.size() > 0) begin
                check_value("cycles from start to first request",
                            first_req_cycle - start_cycle, 2);
            end else begin
                check_value("cycles from start to done", cycle - start_cycle, 2);
            end
        end
        if (errors == err_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", name);
        end
    endtask

    initial begin
        data_t s;
        data_t e;
        data_t st;
        data_t b;
        start_i           = 1'b0;
        rsp_valid_i       = 1'b0;
        rsp_dest_i        = DEST_CONFIG;
        rsp_field_i       = FIELD_INDEX_START;
        rsp_data_i        = '0;
        areset_csr_engine = 1'b1;
        repeat (4) @(posedge ap_clk);
        #1;
        areset_csr_engine = 1'b0;

        // Base address still unwritten
        write_field(FIELD_INDEX_START, 32'd3);
        write_field(FIELD_INDEX_END, 32'd9);
        write_field(FIELD_STRIDE, 32'd1);
        send_config();
        run_job("start before config ready", 1'b0, 1'b0);

        configure(32'd20, 32'd10, 32'd1, 32'h0000_4000);
        run_job("empty range", 1'b1, 1'b0);
        configure(32'hABCD_0005, 32'h1234_0028, 32'hFFFF_0003, 32'h1000_0000);
        run_job("basic job", 1'b1, 1'b0);
        configure(32'd2, 32'd9, 32'h5555_0000, 32'hFFFF_FFF0);
        run_job("zero stride", 1'b1, 1'b0);
        configure(32'd0, 32'd12, 32'd3, 32'h0000_0100);
        run_job("withheld responses", 1'b1, 1'b1);

        for (int j = 0; j < 20; j++) begin
            s  = $random(seed);
            e  = $random(seed);
            st = $random(seed);
            b  = $random(seed);
            s[`CSR_INDEX_W-1:0]  = 16'd8 + s[7:0];
            e[`CSR_INDEX_W-1:0]  = s[`CSR_INDEX_W-1:0] + e[5:0] - 16'd6;
            st[`CSR_INDEX_W-1:0] = st[2:0];
            configure(s, e, st, b);
            run_job($sformatf("random job %0d", j), 1'b1, 1'b0);
        end

        errors += csr_index_engine_inst.asserts_inst.assert_errors;
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_csr_index_engine

//--- files.f
+incdir+.
csr_index_pkg.sv
csr_index_input_stage.sv
csr_index_config.sv
csr_index_generator.sv
csr_index_engine.sv
csr_index_engine_asserts.sv
tb_csr_index_engine.sv

//--- Bender.yml
package:
  name: csr_index_engine

sources:
  - include_dirs:
      - .
    files:
      - csr_index_pkg.sv
      - csr_index_input_stage.sv
      - csr_index_config.sv
      - csr_index_generator.sv
      - csr_index_engine.sv
      - target: simulation
        files:
          - csr_index_engine_asserts.sv
          - tb_csr_index_engine.sv
